/* rtl/dagPkg.sv */
package dagPkg;

  // Register and bus widths of the second DAG
  localparam int WordWidth = 14;
  localparam int BusWidth  = 16;

  // Each bank holds registers 4 to 7
  localparam int NumRegs = 4;

  // Number of sign bits added above a register word on the data-memory bus
  localparam int SignBits = BusWidth - WordWidth;

  // A single DAG register word
  typedef logic [WordWidth-1:0] dagWord_t;

  // A data-memory bus word
  typedef logic [BusWidth-1:0] busWord_t;

  // Register index, 0 selects register 4 and 3 selects register 7
  typedef logic [$clog2(NumRegs)-1:0] regIdx_t;

  // One bit per register 4 to 7, bit 0 is register 4
  typedef logic [NumRegs-1:0] regMask_t;

  // Instruction fields that steer the I/L and M register selection
  typedef struct packed {
    logic       double;
    logic       idJump;
    logic [7:0] ir;
  } instrFields_t;

  // Destinations of a register move from the data-memory bus
  typedef struct packed {
    regMask_t mtI;
    regMask_t mtL;
    regMask_t mtM;
  } moveCmd_t;

  // Readback sources and the bus drive enable
  typedef struct packed {
    regMask_t mfI;
    regMask_t mfL;
    regMask_t mfM;
    logic     mfDag;
  } readCmd_t;

  // Per-register write enables of one bank with the shared write data
  typedef struct packed {
    regMask_t we;
    dagWord_t data;
  } bankWrite_t;

  // Operand handed to the address adder
  typedef struct packed {
    dagWord_t i;
    dagWord_t l;
    dagWord_t m;
  } dagOperand_t;

endpackage

/* rtl/dagFieldDecode.sv */
`timescale 1ns/1ps

module dagFieldDecode
(
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  logic                 goE,
  input  logic                 exEn,
  input  logic                 post2E,
  input  dagPkg::instrFields_t fields,
  input  dagPkg::moveCmd_t     move,
  input  dagPkg::dagWord_t     newI2,
  input  dagPkg::dagWord_t     dmdIn,
  output dagPkg::regIdx_t      ilR,
  output dagPkg::regIdx_t      mR,
  output dagPkg::bankWrite_t   iWrite,
  output dagPkg::bankWrite_t   lWrite,
  output dagPkg::bankWrite_t   mWrite
);

  import dagPkg::*;

  // Execute-stage copy of the I/L field, used by the post-modify write
  regIdx_t ilE;

  // Register fields of the instruction in the read stage.
  // Double and indirect-jump forms take the I/L pair from the upper bits
  always_comb
  begin
    if (fields.double || fields.idJump)
    begin
      ilR = fields.ir[7:6];
    end
    else
    begin
      ilR = fields.ir[3:2];
    end
  end

  // Only the double form moves the M field
  always_comb
  begin
    if (fields.double)
    begin
      mR = fields.ir[5:4];
    end
    else
    begin
      mR = fields.ir[1:0];
    end
  end

  // The field follows the instruction into execute on a pipeline advance
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      ilE <= '0;
    end
    else if (goE)
    begin
      ilE <= ilR;
    end
  end

  // I bank takes either a bus move or the modified address from the adder
  always_comb
  begin
    iWrite.data = post2E ? newI2 : dmdIn;
    for (int k = 0; k < NumRegs; k++)
    begin
      iWrite.we[k] = exEn && (move.mtI[k] || (post2E && (ilE == regIdx_t'(k))));
    end
  end

  // L and M banks are written only by moves from the bus
  always_comb
  begin
    lWrite.data = dmdIn;
    mWrite.data = dmdIn;
    for (int k = 0; k < NumRegs; k++)
    begin
      lWrite.we[k] = exEn && move.mtL[k];
      mWrite.we[k] = exEn && move.mtM[k];
    end
  end

endmodule

/* rtl/dagRegBank.sv */
`timescale 1ns/1ps

module dagRegBank
(
  input  logic               DSPCLK,
  input  logic               RST,
  input  dagPkg::bankWrite_t wr,
  input  dagPkg::regIdx_t    rdIdx,
  input  dagPkg::regMask_t   rbMask,
  output dagPkg::dagWord_t   rdData,
  output dagPkg::dagWord_t   rbData
);

  import dagPkg::*;

  // Registers 4 to 7 of this bank
  dagWord_t regs [NumRegs];

  // Write enables are already qualified by the decoder
  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      for (int k = 0; k < NumRegs; k++)
      begin
        regs[k] <= '0;
      end
    end
    else
    begin
      for (int k = 0; k < NumRegs; k++)
      begin
        if (wr.we[k])
        begin
          regs[k] <= wr.data;
        end
      end
    end
  end

  // Operand read sees a write made in the same cycle
  always_comb
  begin
    if (wr.we[rdIdx])
    begin
      rdData = wr.data;
    end
    else
    begin
      rdData = regs[rdIdx];
    end
  end

  // AND-OR readback, an empty mask reads zero
  always_comb
  begin
    rbData = '0;
    for (int k = 0; k < NumRegs; k++)
    begin
      rbData = rbData | ({WordWidth{rbMask[k]}} & regs[k]);
    end
  end

endmodule

/* rtl/dagOperandStage.sv */
`timescale 1ns/1ps

module dagOperandStage
(
  input  logic                DSPCLK,
  input  logic                RST,
  input  logic                goE,
  input  logic                dag2En,
  input  logic                mfDag,
  input  dagPkg::dagWord_t    iRd,
  input  dagPkg::dagWord_t    lRd,
  input  dagPkg::dagWord_t    mRd,
  input  dagPkg::dagWord_t    iRb,
  input  dagPkg::dagWord_t    lRb,
  input  dagPkg::dagWord_t    mRb,
  output dagPkg::dagOperand_t operand,
  output dagPkg::busWord_t    dmdOut
);

  import dagPkg::*;

  logic     loadEn;
  dagWord_t rbMerged;

  // The operand only moves when the pipeline advances with DAG2 in use
  assign loadEn = goE && dag2En;

  always_ff @(posedge DSPCLK or posedge RST)
  begin
    if (RST)
    begin
      operand <= '0;
    end
    else if (loadEn)
    begin
      operand.i <= iRd;
      operand.l <= lRd;
      operand.m <= mRd;
    end
  end

  // At most one readback source is selected, so OR-ing the banks is enough
  assign rbMerged = iRb | lRb | mRb;

  // The upper bus bits follow the sign of the M register only.
  // I and L readback leaves them low
  always_comb
  begin
    if (mfDag)
    begin
      dmdOut = {{SignBits{mRb[WordWidth-1]}}, rbMerged};
    end
    else
    begin
      dmdOut = '0;
    end
  end

endmodule

/* rtl/dagTop.sv */
`timescale 1ns/1ps

module dagTop
(
  input  logic                 DSPCLK,
  input  logic                 RST,
  input  logic                 goE,
  input  logic                 exEn,
  input  logic                 dag2En,
  input  logic                 post2E,
  input  dagPkg::instrFields_t fields,
  input  dagPkg::moveCmd_t     move,
  input  dagPkg::readCmd_t     readSel,
  input  dagPkg::dagWord_t     newI2,
  input  dagPkg::dagWord_t     dmdIn,
  output dagPkg::dagOperand_t  operand,
  output dagPkg::busWord_t     dmdOut
);

  import dagPkg::*;

  // Read indices for the current instruction
  regIdx_t    ilR;
  regIdx_t    mR;

  // Bank write commands
  bankWrite_t iWrite;
  bankWrite_t lWrite;
  bankWrite_t mWrite;

  // Bypassed operand values and readback values
  dagWord_t   iRd;
  dagWord_t   lRd;
  dagWord_t   mRd;
  dagWord_t   iRb;
  dagWord_t   lRb;
  dagWord_t   mRb;

  dagFieldDecode decode0
  (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .goE    (goE),
    .exEn   (exEn),
    .post2E (post2E),
    .fields (fields),
    .move   (move),
    .newI2  (newI2),
    .dmdIn  (dmdIn),
    .ilR    (ilR),
    .mR     (mR),
    .iWrite (iWrite),
    .lWrite (lWrite),
    .mWrite (mWrite)
  );

  // I and L share one field, M has its own
  dagRegBank iBank
  (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .wr     (iWrite),
    .rdIdx  (ilR),
    .rbMask (readSel.mfI),
    .rdData (iRd),
    .rbData (iRb)
  );

  dagRegBank lBank
  (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .wr     (lWrite),
    .rdIdx  (ilR),
    .rbMask (readSel.mfL),
    .rdData (lRd),
    .rbData (lRb)
  );

  dagRegBank mBank
  (
    .DSPCLK (DSPCLK),
    .RST    (RST),
    .wr     (mWrite),
    .rdIdx  (mR),
    .rbMask (readSel.mfM),
    .rdData (mRd),
    .rbData (mRb)
  );

  dagOperandStage opStage0
  (
    .DSPCLK  (DSPCLK),
    .RST     (RST),
    .goE     (goE),
    .dag2En  (dag2En),
    .mfDag   (readSel.mfDag),
    .iRd     (iRd),
    .lRd     (lRd),
    .mRd     (mRd),
    .iRb     (iRb),
    .lRb     (lRb),
    .mRb     (mRb),
    .operand (operand),
    .dmdOut  (dmdOut)
  );

endmodule

/* verif/dagProps.sv */
`timescale 1ns/1ps

module dagProps
(
  input logic                DSPCLK,
  input logic                RST,
  input logic                goE,
  input logic                dag2En,
  input logic                exEn,
  input logic                post2E,
  input dagPkg::readCmd_t    readSel,
  input dagPkg::dagWord_t    newI2,
  input dagPkg::bankWrite_t  iWrite,
  input dagPkg::dagOperand_t operand,
  input dagPkg::busWord_t    dmdOut
);

  // Without a qualified advance the operand keeps its value
  operandHeld: assert property (@(posedge DSPCLK) disable iff (RST)
    !(goE && dag2En) |=> $stable(operand))
    else $error("operand changed without goE and dag2En");

  busQuiet: assert property (@(posedge DSPCLK) disable iff (RST)
    !readSel.mfDag |-> dmdOut == '0)
    else $error("dmdOut driven while mfDag is low");

  // Post-modify writes the adder result into the I bank
  postData: assert property (@(posedge DSPCLK) disable iff (RST)
    (post2E && exEn) |-> iWrite.data == newI2)
    else $error("I write data differs from newI2 during post-modify");

endmodule

bind dagTop dagProps props0
(
  .DSPCLK  (DSPCLK),
  .RST     (RST),
  .goE     (goE),
  .dag2En  (dag2En),
  .exEn    (exEn),
  .post2E  (post2E),
  .readSel (readSel),
  .newI2   (newI2),
  .iWrite  (iWrite),
  .operand (operand),
  .dmdOut  (dmdOut)
);

/* verif/dagTb.sv */
`timescale 1ns/1ps

module dagTb;

  import dagPkg::*;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 16;
  localparam int NumLoads    = 200;
  localparam int NumBypass   = 40;
  localparam int NumPost     = 30;
  localparam int NumQuiet    = 60;
  // Idle cycles, one move and one readback per register, three cycles per post-modify case
  localparam int TotalCycles = ResetCycles + 9 + 2 * 3 * NumRegs + NumLoads + NumBypass
                               + 3 * NumPost + NumQuiet;
  localparam int TimeoutNs   = (TotalCycles + 100) * ClkPeriod;

  logic         DSPCLK = 1'b0;
  logic         RST;
  logic         goE;
  logic         exEn;
  logic         dag2En;
  logic         post2E;
  instrFields_t fields;
  moveCmd_t     move;
  readCmd_t     readSel;
  dagWord_t     newI2;
  dagWord_t     dmdIn;
  dagOperand_t  operand;
  busWord_t     dmdOut;

  integer       seed = 32'hf59d_0a3f;
  logic [31:0]  rnd;

  // Reference state as it stands after the most recent rising edge
  dagWord_t     modelI [NumRegs];
  dagWord_t     modelL [NumRegs];
  dagWord_t     modelM [NumRegs];
  regIdx_t      modelIlE;
  dagOperand_t  modelOp;

  dagTop dut0
  (
    .DSPCLK  (DSPCLK),
    .RST     (RST),
    .goE     (goE),
    .exEn    (exEn),
    .dag2En  (dag2En),
    .post2E  (post2E),
    .fields  (fields),
    .move    (move),
    .readSel (readSel),
    .newI2   (newI2),
    .dmdIn   (dmdIn),
    .operand (operand),
    .dmdOut  (dmdOut)
  );

  always #(ClkPeriod / 2) DSPCLK = ~DSPCLK;

  task automatic stopWithFailure(string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic checkOperand(dagOperand_t exp, dagOperand_t act);
    if (act !== exp)
      stopWithFailure($sformatf("[ERROR] operand expected %h actual %h", exp, act));
  endtask

  task automatic checkBus(busWord_t exp, busWord_t act);
    if (act !== exp)
      stopWithFailure($sformatf("[ERROR] dmdOut expected %h actual %h", exp, act));
  endtask

  function automatic regIdx_t selectIl(instrFields_t f);
    return (f.double || f.idJump) ? f.ir[7:6] : f.ir[3:2];
  endfunction

  function automatic regIdx_t selectM(instrFields_t f);
    return f.double ? f.ir[5:4] : f.ir[1:0];
  endfunction

  // Bus word for a readback selection, only the M part sets the upper bits
  function automatic busWord_t refBus(readCmd_t sel);
    dagWord_t merged;
    dagWord_t mPart;
    merged = '0;
    mPart  = '0;
    for (int k = 0; k < NumRegs; k++)
    begin
      merged = merged | (sel.mfI[k] ? modelI[k] : '0) | (sel.mfL[k] ? modelL[k] : '0);
      mPart  = mPart | (sel.mfM[k] ? modelM[k] : '0);
    end
    return sel.mfDag ? {{(BusWidth - WordWidth){mPart[WordWidth-1]}}, merged | mPart} : '0;
  endfunction

  // A register written in the same cycle hands its new value to the operand
  function automatic dagOperand_t refOperand(regIdx_t il, regIdx_t mi, regMask_t weI,
                                             dagWord_t iData);
    dagOperand_t op;
    op.i = weI[il] ? iData : modelI[il];
    op.l = (exEn && move.mtL[il]) ? dmdIn : modelL[il];
    op.m = (exEn && move.mtM[mi]) ? dmdIn : modelM[mi];
    return op;
  endfunction

  task automatic resetModel();
    for (int k = 0; k < NumRegs; k++)
    begin
      modelI[k] = '0;
      modelL[k] = '0;
      modelM[k] = '0;
    end
    modelIlE = '0;
    modelOp  = '0;
  endtask

  // Takes the inputs that the DUT samples at the coming rising edge
  task automatic stepModel();
    regIdx_t  il;
    regIdx_t  mi;
    regMask_t weI;
    dagWord_t iData;
    il    = selectIl(fields);
    mi    = selectM(fields);
    iData = post2E ? newI2 : dmdIn;
    for (int k = 0; k < NumRegs; k++)
      weI[k] = exEn && (move.mtI[k] || (post2E && modelIlE == regIdx_t'(k)));
    if (goE && dag2En)
      modelOp = refOperand(il, mi, weI, iData);
    if (goE)
      modelIlE = il;
    for (int k = 0; k < NumRegs; k++)
    begin
      if (weI[k])
        modelI[k] = iData;
      if (exEn && move.mtL[k])
        modelL[k] = dmdIn;
      if (exEn && move.mtM[k])
        modelM[k] = dmdIn;
    end
  endtask

  // Compare at the falling edge, then move the model past the next rising edge
  always @(negedge DSPCLK)
  begin
    checkOperand(modelOp, operand);
    checkBus(refBus(readSel), dmdOut);
    if (RST)
      resetModel();
    else
      stepModel();
  end

  task automatic clearInputs();
    goE     <= 1'b0;
    exEn    <= 1'b0;
    dag2En  <= 1'b0;
    post2E  <= 1'b0;
    fields  <= '0;
    move    <= '0;
    readSel <= '0;
    newI2   <= '0;
    dmdIn   <= '0;
  endtask

  task automatic roll();
    rnd = $random(seed);
  endtask

  // Bank 0 is I, 1 is L and 2 is M
  task automatic moveReg(int bank, int k);
    @(posedge DSPCLK);
    clearInputs();
    roll();
    exEn  <= 1'b1;
    dmdIn <= rnd[WordWidth-1:0];
    case (bank)
      0:       move.mtI[k] <= 1'b1;
      1:       move.mtL[k] <= 1'b1;
      default: move.mtM[k] <= 1'b1;
    endcase
  endtask

  task automatic readReg(int bank, int k);
    @(posedge DSPCLK);
    clearInputs();
    readSel.mfDag <= 1'b1;
    case (bank)
      0:       readSel.mfI[k] <= 1'b1;
      1:       readSel.mfL[k] <= 1'b1;
      default: readSel.mfM[k] <= 1'b1;
    endcase
  endtask

  initial
  begin
    regIdx_t il;
    regIdx_t mi;
    resetModel();
    RST <= 1'b1;
    clearInputs();
    repeat (ResetCycles) @(posedge DSPCLK);
    RST <= 1'b0;
    repeat (4) @(posedge DSPCLK);

    for (int b = 0; b < 3; b++)
      for (int k = 0; k < NumRegs; k++)
        moveReg(b, k);
    for (int b = 0; b < 3; b++)
      for (int k = 0; k < NumRegs; k++)
        readReg(b, k);

    // Random operand loads while moves keep running
    repeat (NumLoads)
    begin
      @(posedge DSPCLK);
      clearInputs();
      roll();
      fields <= rnd[9:0];
      goE    <= rnd[10];
      dag2En <= rnd[11];
      exEn   <= rnd[12];
      move   <= rnd[24:13];
      roll();
      dmdIn  <= rnd[WordWidth-1:0];
    end

    // Move into exactly the registers that the operand load selects
    repeat (NumBypass)
    begin
      @(posedge DSPCLK);
      clearInputs();
      roll();
      il = selectIl(rnd[9:0]);
      mi = selectM(rnd[9:0]);
      fields       <= rnd[9:0];
      goE          <= 1'b1;
      dag2En       <= 1'b1;
      exEn         <= 1'b1;
      move.mtI[il] <= 1'b1;
      move.mtL[il] <= 1'b1;
      move.mtM[mi] <= 1'b1;
      dmdIn        <= rnd[31:18];
    end

    repeat (NumPost)
    begin
      @(posedge DSPCLK);
      clearInputs();
      roll();
      il = selectIl(rnd[9:0]);
      fields <= rnd[9:0];
      goE    <= 1'b1;
      dag2En <= rnd[10];
      @(posedge DSPCLK);
      clearInputs();
      roll();
      exEn   <= 1'b1;
      post2E <= 1'b1;
      newI2  <= rnd[WordWidth-1:0];
      readReg(0, il);
    end

    // Bus drive stays off while masks and writes change
    repeat (NumQuiet)
    begin
      @(posedge DSPCLK);
      clearInputs();
      roll();
      readSel <= {rnd[11:0], 1'b0};
      exEn    <= rnd[12];
      move    <= rnd[24:13];
      dmdIn   <= rnd[31:18];
    end

    @(posedge DSPCLK);
    clearInputs();
    repeat (4) @(posedge DSPCLK);
    $display("Result: PASSED");
    $finish;
  end

  initial
  begin
    #(TimeoutNs);
    stopWithFailure($sformatf("Timeout: the run did not finish within %0d ns", TimeoutNs));
  end

endmodule

/* list.f */
rtl/dagPkg.sv
rtl/dagFieldDecode.sv
rtl/dagRegBank.sv
rtl/dagOperandStage.sv
rtl/dagTop.sv
verif/dagProps.sv
verif/dagTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dagTb
FILELIST  ?= list.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

PASS_MSG  := Result: PASSED
FAIL_MSG  := Result: FAILED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

# A missing pass line also counts as failure, for runs stopped by an assertion
sim: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
